// ==== vlog.f ====
+incdir+include
verilog/pwrSeqPkg.sv
verilog/pwrRegPkg.sv
verilog/pwrDomainSeq.sv
verilog/pwrRegBlock.sv
verilog/pwrCtrlTop.sv
tb/pwrCtrlTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the power controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module pwrCtrlTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/VpwrCtrlTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

// ==== include/pwrTbRef.svh ====
`ifndef PWR_TB_REF_SVH
`define PWR_TB_REF_SVH

// ----------------------------------------------------------------------
// Reference timeline for one power domain
// ----------------------------------------------------------------------

// Model phases: idle, power-down half, restore half
localparam int phIdle = 0;
localparam int phDown = 1;
localparam int phUp   = 2;

// Power-down offsets from the request write edge E0
localparam int gateOnAt = 1;
localparam int isoOnAt  = 3;
localparam int saveAt   = 4;
localparam int pwrOffAt = 6;

// Restore offsets from the request clear edge W
function automatic int restoreAt(input int settle);
  return settle + 2;
endfunction

function automatic int upDoneAt(input int settle);
  // Status reads 0 and the domain is idle again
  return settle + 8;
endfunction

// Expected {gateClk, isolate, saveEdge, restoreEdge, pwr1On, pwr2On, nonSrpgRstN}
function automatic logic [6:0] expDomain(input int phase, input int cnt, input int settle);
  logic [6:0] e;
  e = 7'b0000111;
  if (phase == phDown)
  begin
    e[6] = (cnt >= gateOnAt);
    e[5] = (cnt >= isoOnAt);
    e[4] = (cnt == saveAt);
    e[2] = (cnt < pwrOffAt);
    e[1] = (cnt < pwrOffAt);
    e[0] = (cnt < pwrOffAt);
  end
  else if (phase == phUp)
  begin
    // Main switch at W+1, secondary at W+2
    e[2] = 1'b1;
    e[1] = (cnt >= 2);
    e[3] = (cnt == restoreAt(settle));
    e[5] = (cnt < settle + 4);
    e[6] = (cnt < settle + 5);
    e[0] = (cnt >= settle + 7);
  end
  return e;
endfunction

// Expected read data for an address
function automatic logic [31:0] expReadback(input logic [3:0] addr, input logic [7:0] req,
                                            input logic [7:0] status);
  if (addr == addrReq)
    return {24'd0, req};
  else if (addr == addrStatus)
    return {24'd0, status};
  return 32'd0;
endfunction

`endif

// ==== tb/pwrCtrlTb.sv ====
`timescale 1ns/1ps

module pwrCtrlTb
  import pwrRegPkg::*;
();

  localparam int nd     = 3;
  localparam int settle = 28;

  `include "pwrTbRef.svh"

  logic                    pclk24;
  logic                    nprst24;
  logic                    regWrite;
  logic [regAddrWidth-1:0] regAddr;
  logic [regDataWidth-1:0] regWdata;
  logic [regDataWidth-1:0] regRdata;
  logic [nd-1:0] gateClk, isolate, saveEdge, restoreEdge;
  logic [nd-1:0] pwr1On, pwr2On, nonSrpgRstN;

  // Reference model state
  int phase [nd];
  int cnt [nd];
  logic [nd-1:0] reqModel;
  logic [nd-1:0] statusModel;
  logic checkEn;
  int rstCycles;
  logic [16:0] lfsrState;

  pwrCtrlTop #(
    .numDomains   (nd),
    .settleCycles (settle)
  ) UUT (
    .pclk24      (pclk24),
    .nprst24     (nprst24),
    .regWrite    (regWrite),
    .regAddr     (regAddr),
    .regWdata    (regWdata),
    .regRdata    (regRdata),
    .gateClk     (gateClk),
    .isolate     (isolate),
    .saveEdge    (saveEdge),
    .restoreEdge (restoreEdge),
    .pwr1On      (pwr1On),
    .pwr2On      (pwr2On),
    .nonSrpgRstN (nonSrpgRstN)
  );

  initial
  begin
    pclk24 = 1'b0;
    forever #20 pclk24 = ~pclk24;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Fibonacci LFSR, taps 17 and 14
  function automatic logic [16:0] lfsrNext(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic takeBits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      val = (val << 1) | int'(lfsrState[0]);
    end
  endtask

  task automatic reportMismatch(input string msg);
    $display("FAILED %0t: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic reportTimeout(input string msg);
    $display("Timed out waiting: %s", msg);
    $display("Regression failed");
    $fatal(1, "timeout");
  endtask

  task automatic writeReg(input logic [3:0] addr, input logic [31:0] data);
    @(posedge pclk24);
    regWrite <= 1'b1;
    regAddr  <= addr;
    regWdata <= data;
    @(posedge pclk24);
    regWrite <= 1'b0;
  endtask

  // Point the read mux somewhere and hold a cycle
  task automatic setAddr(input logic [3:0] addr);
    @(posedge pclk24);
    regAddr <= addr;
    @(posedge pclk24);
  endtask

  // Outputs looked at mid-cycle, after the edge has settled
  task automatic waitPowerOff(input int d);
    int t;
    t = 0;
    @(negedge pclk24);
    while (pwr1On[d] !== 1'b0)
    begin
      @(negedge pclk24);
      t++;
      if (t > 20)
        reportTimeout("domain power switch never dropped");
    end
  endtask

  task automatic waitAllIdle();
    int t;
    t = 0;
    @(negedge pclk24);
    while (!(gateClk == '0 && isolate == '0 && &pwr2On && &nonSrpgRstN))
    begin
      @(negedge pclk24);
      t++;
      if (t > 200)
        reportTimeout("domains never returned to idle");
    end
  endtask

  // ----------------------------------------------------------------------
  // Reference model, advanced on every rising edge
  // ----------------------------------------------------------------------

  always @(posedge pclk24)
  begin
    if (!nprst24)
    begin
      rstCycles++;
      checkEn = 1'b0;
      reqModel = '0;
      for (int d = 0; d < nd; d++)
      begin
        phase[d] = phIdle;
        cnt[d] = 0;
      end
    end
    else
    begin
      checkEn = 1'b1;
      // Domains see the request level from before this edge
      for (int d = 0; d < nd; d++)
      begin
        case (phase[d])
          phIdle:
            if (reqModel[d])
            begin
              phase[d] = phDown;
              cnt[d] = 1;
            end
          phDown:
            if (cnt[d] < pwrOffAt)
              cnt[d]++;
            else if (!reqModel[d])
            begin
              phase[d] = phUp;
              cnt[d] = 1;
            end
          default:
            if (cnt[d] == upDoneAt(settle) - 1)
            begin
              phase[d] = phIdle;
              cnt[d] = 0;
            end
            else
              cnt[d]++;
        endcase
      end
      if (regWrite && regAddr == addrReq)
        reqModel = regWdata[nd-1:0];
    end
    for (int d = 0; d < nd; d++)
      statusModel[d] = (phase[d] != phIdle);
  end

  // ----------------------------------------------------------------------
  // Comparing process, mid-cycle
  // ----------------------------------------------------------------------

  always @(negedge pclk24)
  begin
    logic [6:0] act;
    logic [6:0] exp;
    if (!nprst24 && rstCycles >= 2)
    begin
      assert (gateClk == '0 && isolate == '0 && saveEdge == '0 && restoreEdge == '0 &&
              &pwr1On && &pwr2On && nonSrpgRstN == '0 && regRdata == '0)
      else
        reportMismatch("outputs differ from reset values");
    end
    else if (checkEn)
    begin
      for (int d = 0; d < nd; d++)
      begin
        act = {gateClk[d], isolate[d], saveEdge[d], restoreEdge[d],
               pwr1On[d], pwr2On[d], nonSrpgRstN[d]};
        exp = expDomain(phase[d], cnt[d], settle);
        assert (act == exp)
        else
          reportMismatch($sformatf("domain %0d outputs %b, expected %b", d, act, exp));
      end
      assert (regRdata == expReadback(regAddr, 8'(reqModel), 8'(statusModel)))
      else
        reportMismatch($sformatf("read of address %0h gave %0h", regAddr, regRdata));
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  initial
  begin
    int v;
    int h;
    regWrite  = 1'b0;
    regAddr   = addrReq;
    regWdata  = '0;
    nprst24   = 1'b0;
    rstCycles = 0;
    checkEn   = 1'b0;
    lfsrState = 17'd66410;
    repeat (16) @(posedge pclk24);
    nprst24 <= 1'b1;

    // Registers after reset, including unmapped reads
    setAddr(addrReq);
    setAddr(addrStatus);
    setAddr(4'h8);
    setAddr(4'hC);

    // Upper bits masked, read-only and unmapped writes ignored
    writeReg(addrReq, 32'hFFFF_FFF8);
    writeReg(addrStatus, 32'h7);
    writeReg(4'h8, 32'h7);
    writeReg(4'h2, 32'h5);
    setAddr(addrReq);
    setAddr(addrStatus);

    // One full shutoff and restore per domain
    for (int d = 0; d < nd; d++)
    begin
      writeReg(addrReq, 32'(1 << d));
      setAddr(addrStatus);
      waitPowerOff(d);
      repeat (5) @(posedge pclk24);
      writeReg(addrReq, 32'd0);
      setAddr(addrStatus);
      waitAllIdle();
    end

    // Request dropped right away, power-down half still completes
    writeReg(addrReq, 32'h2);
    writeReg(addrReq, 32'h0);
    waitAllIdle();

    // Random overlapping requests
    for (int i = 0; i < 24; i++)
    begin
      takeBits(3, v);
      writeReg(addrReq, 32'(v));
      takeBits(1, v);
      if (v == 1)
        setAddr(addrStatus);
      takeBits(5, h);
      repeat (h) @(posedge pclk24);
    end
    writeReg(addrReq, 32'd0);
    waitAllIdle();
    repeat (4) @(posedge pclk24);

    $display("Regression passed");
    $finish;
  end

endmodule

// ==== verilog/pwrCtrlTop.sv ====
`timescale 1ns/1ps

module pwrCtrlTop
  import pwrRegPkg::*, pwrSeqPkg::*;
#(
  parameter int numDomains   = 3,
  parameter int settleCycles = 28
)
(
  input  logic                    pclk24,
  input  logic                    nprst24,

  // Register port
  input  logic                    regWrite,
  input  logic [regAddrWidth-1:0] regAddr,
  input  logic [regDataWidth-1:0] regWdata,
  output logic [regDataWidth-1:0] regRdata,

  // Per-domain controls, bit n for domain n
  output logic [numDomains-1:0]   gateClk,
  output logic [numDomains-1:0]   isolate,
  output logic [numDomains-1:0]   saveEdge,
  output logic [numDomains-1:0]   restoreEdge,
  output logic [numDomains-1:0]   pwr1On,
  output logic [numDomains-1:0]   pwr2On,
  output logic [numDomains-1:0]   nonSrpgRstN
);

  logic [numDomains-1:0] reqBits;
  logic [numDomains-1:0] setStatus;
  logic [numDomains-1:0] clrStatus;

  // ----------------------------------------------------------------------
  // Parameter range checks
  // ----------------------------------------------------------------------

  if (numDomains < 1 || numDomains > 8)
  begin : gBadDomains
    $error("numDomains must be between 1 and 8");
  end

  if (settleCycles < 1 || settleCycles > maxSettleCycles)
  begin : gBadSettle
    $error("settleCycles must be between 1 and maxSettleCycles");
  end

  // ----------------------------------------------------------------------
  // Register block and one sequencer per domain
  // ----------------------------------------------------------------------

  pwrRegBlock #(
    .numDomains (numDomains)
  ) uRegBlock (
    .pclk24    (pclk24),
    .nprst24   (nprst24),
    .regWrite  (regWrite),
    .regAddr   (regAddr),
    .regWdata  (regWdata),
    .regRdata  (regRdata),
    .setStatus (setStatus),
    .clrStatus (clrStatus),
    .reqBits   (reqBits)
  );

  for (genvar n = 0; n < numDomains; n++)
  begin : gDomain
    pwrDomainSeq #(
      .settleCycles (settleCycles)
    ) uSeq (
      .pclk24      (pclk24),
      .nprst24     (nprst24),
      .lowPwrReq   (reqBits[n]),
      .setStatus   (setStatus[n]),
      .clrStatus   (clrStatus[n]),
      .gateClk     (gateClk[n]),
      .isolate     (isolate[n]),
      .saveEdge    (saveEdge[n]),
      .restoreEdge (restoreEdge[n]),
      .pwr1On      (pwr1On[n]),
      .pwr2On      (pwr2On[n]),
      .nonSrpgRstN (nonSrpgRstN[n])
    );
  end

endmodule

// ==== verilog/pwrRegBlock.sv ====
`timescale 1ns/1ps

module pwrRegBlock
  import pwrRegPkg::*;
#(
  parameter int numDomains = 3
)
(
  input  logic                    pclk24,
  input  logic                    nprst24,

  // Register write strobe and address/data
  input  logic                    regWrite,
  input  logic [regAddrWidth-1:0] regAddr,
  input  logic [regDataWidth-1:0] regWdata,

  // Combinational read data
  output logic [regDataWidth-1:0] regRdata,

  // Pulses from the sequencers
  input  logic [numDomains-1:0]   setStatus,
  input  logic [numDomains-1:0]   clrStatus,

  // Request levels to the sequencers
  output logic [numDomains-1:0]   reqBits
);

  logic [numDomains-1:0] reqReg;
  logic [numDomains-1:0] statusReg;

  // ----------------------------------------------------------------------
  // Request register
  // ----------------------------------------------------------------------

  // Only the request address is writable, upper data bits dropped
  always_ff @(posedge pclk24 or negedge nprst24)
  begin
    if (!nprst24)
      reqReg <= '0;
    else if (regWrite && regAddr == addrReq)
      reqReg <= regWdata[numDomains-1:0];
  end

  assign reqBits = reqReg;

  // ----------------------------------------------------------------------
  // Status register
  // ----------------------------------------------------------------------

  // Set on shutoff start, cleared when the restore completes
  always_ff @(posedge pclk24 or negedge nprst24)
  begin
    if (!nprst24)
      statusReg <= '0;
    else
      statusReg <= (statusReg | setStatus) & ~clrStatus;
  end

  // ----------------------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------------------

  always_comb
  begin
    // Unmapped addresses read zero
    regRdata = '0;
    case (regAddr)
      addrReq:
        regRdata[numDomains-1:0] = reqReg;
      addrStatus:
        regRdata[numDomains-1:0] = statusReg;
      default:
        regRdata = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // A sequencer never sets and clears its status bit at once
  aNoSetAndClear: assert property (@(posedge pclk24) disable iff (!nprst24)
    (setStatus & clrStatus) == '0);

endmodule

// ==== verilog/pwrDomainSeq.sv ====
`timescale 1ns/1ps

module pwrDomainSeq
  import pwrSeqPkg::*;
#(
  parameter int settleCycles = 28
)
(
  input  logic pclk24,
  input  logic nprst24,

  // Level from the request register
  input  logic lowPwrReq,

  // Status register pulses
  output logic setStatus,
  output logic clrStatus,

  // Domain controls
  output logic gateClk,
  output logic isolate,
  output logic saveEdge,
  output logic restoreEdge,
  output logic pwr1On,
  output logic pwr2On,
  output logic nonSrpgRstN
);

  pwrSeqState state;
  pwrSeqState nextState;

  // Counts cycles spent in PwrOn2
  logic [settleCntWidth-1:0] settleCnt;

  // Registered reset release for non-retention flops
  logic rstRelease;

  logic settleDone;

  // ----------------------------------------------------------------------
  // Next state logic
  // ----------------------------------------------------------------------

  // Last settle cycle reached
  assign settleDone = (settleCnt == settleCntWidth'(settleCycles - 1));

  always_comb
  begin
    nextState = state;
    unique case (state)
      // Wait for software to ask for shutoff
      Init:
        if (lowPwrReq)
          nextState = ClkOff;
      ClkOff:
        nextState = Wait1;
      // Give the clock gate a cycle to settle
      Wait1:
        nextState = Isolate;
      Isolate:
        nextState = SaveEdge;
      SaveEdge:
        nextState = PrePwrOff;
      PrePwrOff:
        nextState = PwrOff;
      // Stay down until the request is dropped
      PwrOff:
        if (!lowPwrReq)
          nextState = PwrOn1;
      PwrOn1:
        nextState = PwrOn2;
      // Secondary switch on, hold for the settle interval
      PwrOn2:
        if (settleDone)
          nextState = RestoreEdge;
      RestoreEdge:
        nextState = Wait2;
      Wait2:
        nextState = DeIsolate;
      DeIsolate:
        nextState = ClkOn;
      ClkOn:
        nextState = Wait3;
      // Clock running again before reset release
      Wait3:
        nextState = RstClr;
      RstClr:
        nextState = Init;
      default:
        nextState = Init;
    endcase
  end

  always_ff @(posedge pclk24 or negedge nprst24)
  begin
    if (!nprst24)
      state <= Init;
    else
      state <= nextState;
  end

  // ----------------------------------------------------------------------
  // Settle counter
  // ----------------------------------------------------------------------

  // Runs only while staying in PwrOn2, zero everywhere else
  always_ff @(posedge pclk24 or negedge nprst24)
  begin
    if (!nprst24)
      settleCnt <= '0;
    else if (state == PwrOn2 && nextState == PwrOn2)
      settleCnt <= settleCnt + 1'b1;
    else
      settleCnt <= '0;
  end

  // ----------------------------------------------------------------------
  // Registered control outputs, all decoded from the next state
  // ----------------------------------------------------------------------

  always_ff @(posedge pclk24 or negedge nprst24)
  begin
    if (!nprst24)
    begin
      gateClk     <= 1'b0;
      isolate     <= 1'b0;
      saveEdge    <= 1'b0;
      restoreEdge <= 1'b0;
      // Both switches on out of reset
      pwr1On      <= 1'b1;
      pwr2On      <= 1'b1;
      rstRelease  <= 1'b0;
    end
    else
    begin
      // Clock runs only around the idle state
      gateClk     <= !(nextState inside {ClkOn, Wait3, RstClr, Init});
      // Isolation spans save, power off and restore
      isolate     <= nextState inside {Isolate, SaveEdge, PrePwrOff, PwrOff,
                                       PwrOn1, PwrOn2, RestoreEdge, Wait2};
      saveEdge    <= (nextState == SaveEdge);
      restoreEdge <= (nextState == RestoreEdge);
      // Main switch first on, secondary one cycle later
      pwr1On      <= (nextState != PwrOff);
      pwr2On      <= !(nextState inside {PwrOff, PwrOn1});
      // Non-retention reset held from power off until RstClr
      rstRelease  <= nextState inside {Init, ClkOff, Wait1, Isolate, SaveEdge,
                                       PrePwrOff, RstClr};
    end
  end

  // System reset also forces the non-retention reset
  assign nonSrpgRstN = rstRelease & nprst24;

  // Status pulses for the register block
  assign setStatus = (nextState == ClkOff);
  assign clrStatus = (state == RstClr);

  // ----------------------------------------------------------------------
  // Sequence checks
  // ----------------------------------------------------------------------

  // Isolation follows the clock gate by two cycles
  aIsoAfterGate: assert property (@(posedge pclk24) disable iff (!nprst24)
    $rose(gateClk) |-> ##2 $rose(isolate));

  // Both switches drop together
  aPwrOffTogether: assert property (@(posedge pclk24) disable iff (!nprst24)
    $fell(pwr1On) |-> $fell(pwr2On));

  // Secondary switch on one cycle behind the main one
  aPwr2AfterPwr1: assert property (@(posedge pclk24) disable iff (!nprst24)
    $rose(pwr1On) |=> pwr2On);

  // State save only with the domain powered
  aSaveWhilePowered: assert property (@(posedge pclk24) disable iff (!nprst24)
    !(saveEdge && !pwr1On));

endmodule

// ==== verilog/pwrRegPkg.sv ====
package pwrRegPkg;

  // ----------------------------------------------------------------------
  // Control register port geometry
  // ----------------------------------------------------------------------

  // Read and write data width
  localparam int regDataWidth = 32;

  // Byte address width of the register window
  localparam int regAddrWidth = 4;

  // ----------------------------------------------------------------------
  // Register map
  // ----------------------------------------------------------------------

  // Low-power request, read/write, bit n belongs to domain n
  localparam logic [regAddrWidth-1:0] addrReq = 4'h0;

  // Shutoff status, read only, bit n high while domain n is cycling
  localparam logic [regAddrWidth-1:0] addrStatus = 4'h4;

endpackage

// ==== verilog/pwrSeqPkg.sv ====
package pwrSeqPkg;

  // ----------------------------------------------------------------------
  // Shutoff sequencer state encoding
  // ----------------------------------------------------------------------

  // Power-down half runs Init to PwrOff, restore half runs PwrOn1 to RstClr
  typedef enum logic [3:0]
  {
    Init        = 4'd0,
    ClkOff      = 4'd1,
    Wait1       = 4'd2,
    Isolate     = 4'd3,
    SaveEdge    = 4'd4,
    PrePwrOff   = 4'd5,
    PwrOff      = 4'd6,
    PwrOn1      = 4'd7,
    PwrOn2      = 4'd8,
    RestoreEdge = 4'd9,
    Wait2       = 4'd10,
    DeIsolate   = 4'd11,
    ClkOn       = 4'd12,
    Wait3       = 4'd13,
    RstClr      = 4'd14
  } pwrSeqState;

  // ----------------------------------------------------------------------
  // Settle interval limits
  // ----------------------------------------------------------------------

  // Longest supported settle interval in PwrOn2, in clock cycles
  localparam int maxSettleCycles = 255;

  // Settle counter width follows from the limit above
  localparam int settleCntWidth = $clog2(maxSettleCycles + 1);

endpackage
